//--- frame_blender.f
blend_pkg.sv
layer_if.sv
raster_counter.sv
layer_window.sv
alpha_mixer.sv
frame_blender.sv
tb_frame_blender.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status follows the simulation
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f frame_blender.f \
		--top-module tb_frame_blender -o sim_frame_blender &&
	./obj_dir/sim_frame_blender ||
	{ echo "simulation failed"; exit 1; }

//--- tb_frame_blender.sv
`timescale 1ns/1ns

module tb_frame_blender;

	localparam int FRAMES = 3;
	localparam int PIXELS = 48;
	localparam int OVL_PIXELS = 12;
	localparam int JUNK = 3;
	localparam int MAX_CYCLES = FRAMES * PIXELS * 8 + 16;

	logic clk = 1'b0;
	logic resetn;
	logic order_1over2;
	logic [11:0] out_width, out_height;
	logic s0_tvalid, s0_tuser, s0_tlast, s0_tready;
	logic [31:0] s0_tdata;
	logic s1_tvalid, s1_tuser, s1_tlast, s1_tready;
	logic [7:0] s1_tdata;
	logic s2_tvalid, s2_tuser, s2_tlast, s2_tready;
	logic [7:0] s2_tdata;
	logic m_tvalid, m_tuser, m_tlast, m_tready;
	logic [23:0] m_tdata;

	logic [31:0] base_img [FRAMES][PIXELS];
	logic [7:0] ov1_img [FRAMES][OVL_PIXELS];
	logic [7:0] ov2_img [FRAMES][OVL_PIXELS];
	integer seed = 32'h2e71;
	int n0 = 0, n1 = 0, n2 = 0;
	int out_count = 0;
	int cycles = 0;
	logic s0_fire = 1'b0, s1_fire = 1'b0, s2_fire = 1'b0;
	logic held = 1'b0;
	logic held_user, held_last;
	logic [23:0] held_data;

	frame_blender DUT (
		.clk(clk), .resetn(resetn), .order_1over2(order_1over2),
		.out_width(out_width), .out_height(out_height),
		.s0_tvalid(s0_tvalid), .s0_tdata(s0_tdata), .s0_tuser(s0_tuser),
		.s0_tlast(s0_tlast), .s0_tready(s0_tready),
		.s0_win_left(12'd0), .s0_win_top(12'd0), .s0_win_width(12'd8), .s0_win_height(12'd6),
		.s1_tvalid(s1_tvalid), .s1_tdata(s1_tdata), .s1_tuser(s1_tuser),
		.s1_tlast(s1_tlast), .s1_tready(s1_tready),
		.s1_win_left(12'd1), .s1_win_top(12'd1), .s1_win_width(12'd4), .s1_win_height(12'd3),
		.s2_tvalid(s2_tvalid), .s2_tdata(s2_tdata), .s2_tuser(s2_tuser),
		.s2_tlast(s2_tlast), .s2_tready(s2_tready),
		.s2_win_left(12'd3), .s2_win_top(12'd2), .s2_win_width(12'd4), .s2_win_height(12'd3),
		.m_tvalid(m_tvalid), .m_tdata(m_tdata), .m_tuser(m_tuser), .m_tlast(m_tlast),
		.m_tready(m_tready)
	);

	always #5 clk = ~clk;

	function automatic logic coin_flip();
		int r;
		r = $random(seed);
		return r[1:0] != 2'b00;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// Reference pixel from the stored images
	function automatic logic [23:0] expected_rgb(input int f, input int col, input int row);
		logic [31:0] px;
		logic [7:0] a, g;
		logic [15:0] s;
		logic [23:0] rgb;
		logic in1, in2;
		px = base_img[f][row * 8 + col];
		a = px[31:24];
		in1 = (col >= 1) && (col < 5) && (row >= 1) && (row < 4);
		in2 = (col >= 3) && (col < 7) && (row >= 2) && (row < 5);
		if (!in1 && !in2)
			return px[23:0];
		// Overlay 1 is on top only in the last frame
		if (in1 && (!in2 || f == 2))
			g = ov1_img[f][(row - 1) * 4 + (col - 1)];
		else
			g = ov2_img[f][(row - 2) * 4 + (col - 3)];
		for (int k = 0; k < 3; k++) begin
			s = 16'(px[k * 8 +: 8]) * (16'd255 - 16'(a)) + 16'(g) * 16'(a);
			rgb[k * 8 +: 8] = s[15:8];
		end
		return rgb;
	endfunction

	////////////////////
	// Output checks

	always @(posedge clk) begin
		int f, pos;
		s0_fire <= s0_tvalid && s0_tready;
		s1_fire <= s1_tvalid && s1_tready;
		s2_fire <= s2_tvalid && s2_tready;
		if (held) begin
			assert (m_tvalid && m_tdata == held_data && m_tuser == held_user
				&& m_tlast == held_last)
			else stop_with_error($sformatf("error at %0t: output changed while stalled", $time));
		end
		held = m_tvalid && !m_tready;
		held_data = m_tdata;
		held_user = m_tuser;
		held_last = m_tlast;
		if (m_tvalid && m_tready) begin
			f = out_count / PIXELS;
			pos = out_count % PIXELS;
			assert (m_tdata == expected_rgb(f, pos % 8, pos / 8))
			else stop_with_error($sformatf("error at %0t: frame %0d pixel %0d is %h, expected %h",
				$time, f, pos, m_tdata, expected_rgb(f, pos % 8, pos / 8)));
			assert (m_tuser == (pos == 0) && m_tlast == (pos % 8 == 7))
			else stop_with_error($sformatf("error at %0t: frame %0d pixel %0d has flags %b%b",
				$time, f, pos, m_tuser, m_tlast));
			out_count = out_count + 1;
		end
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_with_error("Timeout: the frames did not complete in time");
	end

	////////////////////
	// Layer sources

	always @(negedge clk) begin
		if (resetn) begin
			if (s0_fire)
				n0 = n0 + 1;
			if (!s0_tvalid || s0_fire) begin
				// Frame 3 waits until the order switch is in place
				if (n0 < FRAMES * PIXELS && !(n0 >= 2 * PIXELS && out_count < 2 * PIXELS)
					&& coin_flip()) begin
					s0_tvalid = 1'b1;
					s0_tdata = base_img[n0 / PIXELS][n0 % PIXELS];
					s0_tuser = (n0 % PIXELS == 0);
					s0_tlast = (n0 % 8 == 7);
				end else begin
					s0_tvalid = 1'b0;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (resetn) begin
			if (s1_fire)
				n1 = n1 + 1;
			if (!s1_tvalid || s1_fire) begin
				if (n1 < FRAMES * OVL_PIXELS && coin_flip()) begin
					s1_tvalid = 1'b1;
					s1_tdata = ov1_img[n1 / OVL_PIXELS][n1 % OVL_PIXELS];
					s1_tuser = (n1 % OVL_PIXELS == 0);
					s1_tlast = (n1 % 4 == 3);
				end else begin
					s1_tvalid = 1'b0;
				end
			end
		end
	end

	// Overlay 2 leads with junk ahead of its first frame start
	always @(negedge clk) begin
		int k;
		if (resetn) begin
			if (s2_fire)
				n2 = n2 + 1;
			k = n2 - JUNK;
			if (!s2_tvalid || s2_fire) begin
				if (n2 < FRAMES * OVL_PIXELS + JUNK && coin_flip()) begin
					s2_tvalid = 1'b1;
					s2_tdata = (k < 0) ? 8'h5a : ov2_img[k / OVL_PIXELS][k % OVL_PIXELS];
					s2_tuser = (k >= 0) && (k % OVL_PIXELS == 0);
					s2_tlast = (k >= 0) && (k % 4 == 3);
				end else begin
					s2_tvalid = 1'b0;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (resetn) begin
			m_tready = coin_flip();
			order_1over2 = (out_count >= 2 * PIXELS);
		end
	end

	initial begin
		int r;
		resetn = 1'b0;
		order_1over2 = 1'b0;
		out_width = 12'd8;
		out_height = 12'd6;
		m_tready = 1'b0;
		{s0_tvalid, s0_tuser, s0_tlast, s0_tdata} = '0;
		{s1_tvalid, s1_tuser, s1_tlast, s1_tdata} = '0;
		{s2_tvalid, s2_tuser, s2_tlast, s2_tdata} = '0;
		for (int f = 0; f < FRAMES; f++) begin
			for (int p = 0; p < PIXELS; p++)
				base_img[f][p] = $random(seed);
			for (int p = 0; p < OVL_PIXELS; p++) begin
				r = $random(seed);
				ov1_img[f][p] = r[7:0];
				ov2_img[f][p] = r[15:8];
			end
		end
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		wait (out_count == FRAMES * PIXELS);
		@(negedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- frame_blender.sv
`timescale 1ns/1ns

module frame_blender (
	input  logic clk,
	input  logic resetn,
	input  logic order_1over2,
	input  logic [blend_pkg::IMG_WBITS-1:0] out_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] out_height,
	// Layer 0, ARGB base
	input  logic s0_tvalid,
	input  logic [blend_pkg::BASE_WIDTH-1:0] s0_tdata,
	input  logic s0_tuser,
	input  logic s0_tlast,
	output logic s0_tready,
	input  logic [blend_pkg::IMG_WBITS-1:0] s0_win_left,
	input  logic [blend_pkg::IMG_HBITS-1:0] s0_win_top,
	input  logic [blend_pkg::IMG_WBITS-1:0] s0_win_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] s0_win_height,
	// Layer 1, grey overlay
	input  logic s1_tvalid,
	input  logic [blend_pkg::OVERLAY_WIDTH-1:0] s1_tdata,
	input  logic s1_tuser,
	input  logic s1_tlast,
	output logic s1_tready,
	input  logic [blend_pkg::IMG_WBITS-1:0] s1_win_left,
	input  logic [blend_pkg::IMG_HBITS-1:0] s1_win_top,
	input  logic [blend_pkg::IMG_WBITS-1:0] s1_win_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] s1_win_height,
	// Layer 2, grey overlay
	input  logic s2_tvalid,
	input  logic [blend_pkg::OVERLAY_WIDTH-1:0] s2_tdata,
	input  logic s2_tuser,
	input  logic s2_tlast,
	output logic s2_tready,
	input  logic [blend_pkg::IMG_WBITS-1:0] s2_win_left,
	input  logic [blend_pkg::IMG_HBITS-1:0] s2_win_top,
	input  logic [blend_pkg::IMG_WBITS-1:0] s2_win_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] s2_win_height,
	// Blended RGB out
	output logic m_tvalid,
	output logic [blend_pkg::OUT_WIDTH-1:0] m_tdata,
	output logic m_tuser,
	output logic m_tlast,
	input  logic m_tready
);

	logic [blend_pkg::IMG_WBITS-1:0] col_idx;
	logic [blend_pkg::IMG_HBITS-1:0] row_idx;
	logic frame_start;
	logic line_end;
	logic advance;

	layer_if #(.PIXEL_WIDTH(blend_pkg::BASE_WIDTH)) base_if ();
	layer_if #(.PIXEL_WIDTH(blend_pkg::OVERLAY_WIDTH)) ovl1_if ();
	layer_if #(.PIXEL_WIDTH(blend_pkg::OVERLAY_WIDTH)) ovl2_if ();

	raster_counter u_raster (
		.clk         (clk),
		.resetn      (resetn),
		.advance     (advance),
		.out_width   (out_width),
		.out_height  (out_height),
		.col_idx     (col_idx),
		.row_idx     (row_idx),
		.frame_start (frame_start),
		.line_end    (line_end)
	);

	////////////////////
	// Layer windows

	layer_window #(.PIXEL_WIDTH(blend_pkg::BASE_WIDTH)) u_win0 (
		.clk        (clk),
		.resetn     (resetn),
		.col_idx    (col_idx),
		.row_idx    (row_idx),
		.tvalid     (s0_tvalid),
		.tdata      (s0_tdata),
		.tuser      (s0_tuser),
		.tlast      (s0_tlast),
		.tready     (s0_tready),
		.win_left   (s0_win_left),
		.win_top    (s0_win_top),
		.win_width  (s0_win_width),
		.win_height (s0_win_height),
		.lyr        (base_if.source)
	);

	layer_window #(.PIXEL_WIDTH(blend_pkg::OVERLAY_WIDTH)) u_win1 (
		.clk        (clk),
		.resetn     (resetn),
		.col_idx    (col_idx),
		.row_idx    (row_idx),
		.tvalid     (s1_tvalid),
		.tdata      (s1_tdata),
		.tuser      (s1_tuser),
		.tlast      (s1_tlast),
		.tready     (s1_tready),
		.win_left   (s1_win_left),
		.win_top    (s1_win_top),
		.win_width  (s1_win_width),
		.win_height (s1_win_height),
		.lyr        (ovl1_if.source)
	);

	layer_window #(.PIXEL_WIDTH(blend_pkg::OVERLAY_WIDTH)) u_win2 (
		.clk        (clk),
		.resetn     (resetn),
		.col_idx    (col_idx),
		.row_idx    (row_idx),
		.tvalid     (s2_tvalid),
		.tdata      (s2_tdata),
		.tuser      (s2_tuser),
		.tlast      (s2_tlast),
		.tready     (s2_tready),
		.win_left   (s2_win_left),
		.win_top    (s2_win_top),
		.win_width  (s2_win_width),
		.win_height (s2_win_height),
		.lyr        (ovl2_if.source)
	);

	alpha_mixer u_mixer (
		.clk          (clk),
		.resetn       (resetn),
		.order_1over2 (order_1over2),
		.frame_start  (frame_start),
		.line_end     (line_end),
		.m_tready     (m_tready),
		.advance      (advance),
		.m_tvalid     (m_tvalid),
		.m_tdata      (m_tdata),
		.m_tuser      (m_tuser),
		.m_tlast      (m_tlast),
		.base         (base_if.sink),
		.ovl1         (ovl1_if.sink),
		.ovl2         (ovl2_if.sink)
	);

endmodule

//--- alpha_mixer.sv
`timescale 1ns/1ns

module alpha_mixer (
	input  logic clk,
	input  logic resetn,
	input  logic order_1over2,
	input  logic frame_start,
	input  logic line_end,
	input  logic m_tready,
	output logic advance,
	output logic m_tvalid,
	output logic [blend_pkg::OUT_WIDTH-1:0] m_tdata,
	output logic m_tuser,
	output logic m_tlast,
	layer_if.sink base,
	layer_if.sink ovl1,
	layer_if.sink ovl2
);

	blend_pkg::layer_order_e order;
	logic gathered;
	logic ovl_any;
	logic [7:0] alpha;
	logic [blend_pkg::OVERLAY_WIDTH-1:0] grey;
	logic [blend_pkg::OUT_WIDTH-1:0] mixed;

	// c*(255-a) + g*a never exceeds 255*255
	function automatic logic [7:0] blend_channel(
		input logic [7:0] c,
		input logic [7:0] g,
		input logic [7:0] a
	);
		logic [15:0] sum;
		sum = c * (8'd255 - a) + g * a;
		return sum[15:8];
	endfunction

	////////////////////
	// Gather and advance

	assign gathered = (!base.need || base.valid)
		&& (!ovl1.need || ovl1.valid)
		&& (!ovl2.need || ovl2.valid);

	assign advance = gathered && (!m_tvalid || m_tready);

	assign base.next = advance;
	assign ovl1.next = advance;
	assign ovl2.next = advance;

	////////////////////
	// Blend

	assign order = order_1over2 ? blend_pkg::ORDER_1_OVER_2 : blend_pkg::ORDER_2_OVER_1;
	assign ovl_any = ovl1.need || ovl2.need;
	assign alpha = base.data[blend_pkg::BASE_WIDTH-1 -: 8];

	// Topmost covering overlay
	always_comb begin
		if (ovl1.need && ovl2.need)
			grey = (order == blend_pkg::ORDER_1_OVER_2) ? ovl1.data : ovl2.data;
		else if (ovl1.need)
			grey = ovl1.data;
		else
			grey = ovl2.data;
	end

	always_comb begin
		if (ovl_any) begin
			mixed[23:16] = blend_channel(base.data[23:16], grey, alpha);
			mixed[15:8] = blend_channel(base.data[15:8], grey, alpha);
			mixed[7:0] = blend_channel(base.data[7:0], grey, alpha);
		end else begin
			mixed = base.data[blend_pkg::OUT_WIDTH-1:0];
		end
	end

	////////////////////
	// Output stage

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_tvalid <= 1'b0;
			m_tuser <= 1'b0;
			m_tlast <= 1'b0;
		end else if (advance) begin
			m_tvalid <= 1'b1;
			m_tuser <= frame_start;
			m_tlast <= line_end;
		end else if (m_tready) begin
			m_tvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			m_tdata <= mixed;
	end

endmodule

//--- layer_window.sv
`timescale 1ns/1ns

module layer_window #(
	parameter int PIXEL_WIDTH = 8
) (
	input  logic clk,
	input  logic resetn,
	input  logic [blend_pkg::IMG_WBITS-1:0] col_idx,
	input  logic [blend_pkg::IMG_HBITS-1:0] row_idx,
	input  logic tvalid,
	input  logic [PIXEL_WIDTH-1:0] tdata,
	input  logic tuser,
	input  logic tlast,
	output logic tready,
	input  logic [blend_pkg::IMG_WBITS-1:0] win_left,
	input  logic [blend_pkg::IMG_HBITS-1:0] win_top,
	input  logic [blend_pkg::IMG_WBITS-1:0] win_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] win_height,
	layer_if.source lyr
);

	blend_pkg::win_state_e state;
	logic running;
	logic full;
	logic held_sof;
	logic held_eol;
	logic [PIXEL_WIDTH-1:0] held_data;
	logic [blend_pkg::IMG_WBITS-1:0] col_off;
	logic [blend_pkg::IMG_HBITS-1:0] row_off;
	logic in_cols;
	logic in_rows;
	logic at_origin;
	logic at_right;
	logic consume;
	logic accept;
	logic slipped;

	////////////////////
	// Window hit test

	// Offsets wrap when left of or above the window, so check the lower bound too
	assign col_off = col_idx - win_left;
	assign row_off = row_idx - win_top;
	assign in_cols = (col_idx >= win_left) && (col_off < win_width);
	assign in_rows = (row_idx >= win_top) && (row_off < win_height);

	assign at_origin = (col_off == '0) && (row_off == '0);
	assign at_right = (col_off == win_width - 1'b1);

	assign lyr.need = in_cols && in_rows;

	////////////////////
	// Stream side

	assign consume = lyr.next && lyr.need;

	// Frame or line marker used away from where it belongs
	assign slipped = consume && ((held_sof && !at_origin) || (held_eol && !at_right));

	// Room when empty, or when the held pixel leaves this cycle
	assign tready = running && (!full || consume);
	assign accept = tvalid && tready;

	assign lyr.valid = full;
	assign lyr.data = held_data;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running <= 1'b0;
			state <= blend_pkg::WIN_SEEK_SOF;
			full <= 1'b0;
		end else begin
			running <= 1'b1;
			case (state)
				blend_pkg::WIN_SEEK_SOF: begin
					// Junk ahead of the first frame start is dropped
					if (accept && tuser) begin
						state <= blend_pkg::WIN_STREAM;
						full <= 1'b1;
					end
				end
				blend_pkg::WIN_STREAM: begin
					if (slipped) begin
						state <= blend_pkg::WIN_SEEK_SOF;
						full <= 1'b0;
					end else if (accept) begin
						full <= 1'b1;
					end else if (consume) begin
						full <= 1'b0;
					end
				end
				default: begin
					state <= blend_pkg::WIN_SEEK_SOF;
					full <= 1'b0;
				end
			endcase
		end
	end

	// Held pixel with its markers
	always_ff @(posedge clk) begin
		if (accept) begin
			held_data <= tdata;
			held_sof <= tuser;
			held_eol <= tlast;
		end
	end

endmodule

//--- raster_counter.sv
`timescale 1ns/1ns

module raster_counter (
	input  logic clk,
	input  logic resetn,
	input  logic advance,
	input  logic [blend_pkg::IMG_WBITS-1:0] out_width,
	input  logic [blend_pkg::IMG_HBITS-1:0] out_height,
	output logic [blend_pkg::IMG_WBITS-1:0] col_idx,
	output logic [blend_pkg::IMG_HBITS-1:0] row_idx,
	output logic frame_start,
	output logic line_end
);

	logic [blend_pkg::IMG_WBITS-1:0] last_col;
	logic [blend_pkg::IMG_HBITS-1:0] last_row;

	assign last_col = out_width - 1'b1;
	assign last_row = out_height - 1'b1;

	// Position of the next output pixel
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_idx <= '0;
			row_idx <= '0;
		end else if (advance) begin
			if (col_idx != last_col) begin
				col_idx <= col_idx + 1'b1;
			end else begin
				col_idx <= '0;
				// Wrap to the top after the last row
				if (row_idx != last_row)
					row_idx <= row_idx + 1'b1;
				else
					row_idx <= '0;
			end
		end
	end

	assign frame_start = (col_idx == '0) && (row_idx == '0);
	assign line_end = (col_idx == last_col);

endmodule

//--- layer_if.sv
`timescale 1ns/1ns

interface layer_if #(
	parameter int PIXEL_WIDTH = 8
);

	// Raster position lies inside the layer window
	logic need;
	// Holding register has a pixel
	logic valid;
	logic [PIXEL_WIDTH-1:0] data;
	// Mixer consumes the current position this cycle
	logic next;

	modport source (
		output need,
		output valid,
		output data,
		input  next
	);

	modport sink (
		input  need,
		input  valid,
		input  data,
		output next
	);

endinterface

//--- blend_pkg.sv
package blend_pkg;

	////////////////////
	// Raster geometry

	// Column coordinates and width values
	localparam int IMG_WBITS = 12;

	// Row coordinates and height values
	localparam int IMG_HBITS = 12;

	////////////////////
	// Pixel formats

	// Layer 0 is ARGB with alpha in the top byte
	localparam int BASE_WIDTH = 32;

	// Layers 1 and 2 carry a single grey level
	localparam int OVERLAY_WIDTH = 8;

	// Blended RGB on the output stream
	localparam int OUT_WIDTH = 24;

	////////////////////
	// Enumerations

	// Layer window FSM
	typedef enum logic {
		WIN_SEEK_SOF = 1'b0,
		WIN_STREAM   = 1'b1
	} win_state_e;

	// Which overlay wins where both windows cover the position
	typedef enum logic {
		ORDER_2_OVER_1 = 1'b0,
		ORDER_1_OVER_2 = 1'b1
	} layer_order_e;

endpackage
